//--- tag_store_pkg.sv
// Sizes and shared types of the LLC tag store
// Operation enum, stored tag entry, request and result structs
package tag_store_pkg;

  // Cache geometry
  localparam int unsigned NUM_WAYS  = 4;
  localparam int unsigned WAY_BIN_W = $clog2(NUM_WAYS);
  localparam int unsigned INDEX_W   = 4;
  localparam int unsigned NUM_SETS  = 1 << INDEX_W;
  localparam int unsigned TAG_W     = 8;

  // Bit per way, one-hot or mask
  typedef logic [NUM_WAYS-1:0]  way_ind_t;
  // Binary way number
  typedef logic [WAY_BIN_W-1:0] way_bin_t;
  typedef logic [INDEX_W-1:0]   index_t;
  typedef logic [TAG_W-1:0]     tag_t;

  // Operations the tag store accepts
  typedef enum logic {
    OP_LOOKUP = 1'b0,
    OP_FLUSH  = 1'b1
  } tag_op_e;

  // Word held in each tag SRAM
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  // Read data of all ways at one index
  typedef tag_entry_t [NUM_WAYS-1:0] tag_entries_t;

  // Request payload
  typedef struct packed {
    tag_op_e  op;
    index_t   index;
    tag_t     tag;
    // Line will be dirty after this access
    logic     dirty;
    // Target way of a Flush, one-hot
    way_ind_t flush_way;
  } tag_req_t;

  // Result payload
  typedef struct packed {
    // Hit way, victim way or flushed way
    way_ind_t way;
    logic     hit;
    // Selected line is valid and dirty, needs write-back
    logic     evict;
    tag_t     evict_tag;
  } tag_res_t;

endpackage

//--- tag_sram.sv
// Tag memory of one way
// Synchronous read and write, one cycle read latency, read-valid strobe
`timescale 1ns/1ps
module tag_sram (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  tag_store_pkg::index_t     index_i,
  input  tag_store_pkg::tag_entry_t wdata_i,
  output tag_store_pkg::tag_entry_t rdata_o,
  output logic                      rvalid_o
);
  import tag_store_pkg::*;

  tag_entry_t          mem_q [NUM_SETS];
  // Set once an entry was written since reset
  logic [NUM_SETS-1:0] init_q;
  tag_entry_t          rdata_q;
  logic                rvalid_q;

  // Reset clears every entry logically through its flag
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      init_q <= '0;
    end else if (req_i && we_i) begin
      init_q[index_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[index_i] <= wdata_i;
    end
    // Entries never written read back as zero
    if (req_i && !we_i) begin
      rdata_q <= init_q[index_i] ? mem_q[index_i] : '0;
    end
  end

  // Strobe one cycle after each read
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i && !we_i;
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

endmodule

//--- tag_hit_detect.sv
// Tag compare across all ways
// Hit vector and binary number of the hit way
`timescale 1ns/1ps
module tag_hit_detect (
  input  tag_store_pkg::tag_entries_t entries_i,
  input  tag_store_pkg::tag_t         tag_i,
  input  tag_store_pkg::way_ind_t     lock_i,
  output tag_store_pkg::way_ind_t     hit_o,
  output tag_store_pkg::way_bin_t     hit_bin_o
);
  import tag_store_pkg::*;

  way_ind_t tag_equ;
  way_ind_t tag_val;

  // Per-way compare of stored and looked-up tag
  always_comb begin
    for (int unsigned w = 0; w < NUM_WAYS; w++) begin
      tag_equ[w] = entries_i[w].tag == tag_i;
      tag_val[w] = entries_i[w].valid;
    end
  end

  // Scratchpad ways take no part in the search
  assign hit_o = tag_equ & tag_val & ~lock_i;

  // One-hot to binary, OR of the set positions
  always_comb begin
    hit_bin_o = '0;
    for (int unsigned w = 0; w < NUM_WAYS; w++) begin
      if (hit_o[w]) begin
        hit_bin_o = hit_bin_o | way_bin_t'(w);
      end
    end
  end

endmodule

//--- victim_select.sv
// Victim way choice for a Lookup miss
// Invalid unlocked ways first, then global round-robin over unlocked ways
`timescale 1ns/1ps
module victim_select (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  tag_store_pkg::tag_entries_t entries_i,
  input  tag_store_pkg::way_ind_t     lock_i,
  input  logic                        advance_i,
  output tag_store_pkg::way_ind_t     victim_o,
  output logic                        found_o
);
  import tag_store_pkg::*;

  way_bin_t ptr_q;
  way_ind_t free_ways;
  way_bin_t free_bin;
  logic     free_any;
  way_bin_t rr_bin;
  logic     rr_any;
  way_bin_t victim_bin;

  // Unlocked ways holding no line
  always_comb begin
    for (int unsigned w = 0; w < NUM_WAYS; w++) begin
      free_ways[w] = !lock_i[w] && !entries_i[w].valid;
    end
  end

  // Downward scan, so the lowest free way wins
  always_comb begin
    free_bin = '0;
    free_any = 1'b0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (free_ways[w]) begin
        free_bin = way_bin_t'(w);
        free_any = 1'b1;
      end
    end
  end

  // First unlocked way at or after the pointer, with wrap-around
  always_comb begin : rr_scan
    way_bin_t cand;
    rr_bin = ptr_q;
    rr_any = 1'b0;
    for (int unsigned k = 0; k < NUM_WAYS; k++) begin
      cand = ptr_q + way_bin_t'(k);
      if (!rr_any && !lock_i[cand]) begin
        rr_bin = cand;
        rr_any = 1'b1;
      end
    end
  end

  assign victim_bin = free_any ? free_bin : rr_bin;
  // No unlocked way means no victim at all
  assign found_o    = rr_any;
  assign victim_o   = found_o ? (way_ind_t'(1) << victim_bin) : '0;

  // Pointer moves past the way just replaced
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (advance_i) begin
      ptr_q <= victim_bin + way_bin_t'(1);
    end
  end

endmodule

//--- tag_store_ctrl.sv
// Tag store controller
// Operation FSM, request and result registers, SRAM read and write-back control
`timescale 1ns/1ps
module tag_store_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  tag_store_pkg::tag_req_t     req_i,
  input  logic                        valid_i,
  output logic                        ready_o,
  output tag_store_pkg::tag_res_t     res_o,
  output logic                        valid_o,
  input  logic                        ready_i,
  output tag_store_pkg::way_ind_t     ram_req_o,
  output tag_store_pkg::way_ind_t     ram_we_o,
  output tag_store_pkg::index_t       ram_index_o,
  output tag_store_pkg::tag_entry_t   ram_wdata_o,
  input  tag_store_pkg::tag_entries_t entries_i,
  input  tag_store_pkg::way_ind_t     rvalid_i,
  input  tag_store_pkg::way_ind_t     hit_i,
  input  tag_store_pkg::way_bin_t     hit_bin_i,
  input  tag_store_pkg::way_ind_t     victim_i,
  input  logic                        found_i,
  output logic                        advance_o,
  output tag_store_pkg::tag_t         lookup_tag_o
);
  import tag_store_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    READ,
    RESPOND
  } state_e;

  state_e     state_q;
  // READ lasts two cycles, issue then data
  logic       data_phase_q;
  tag_req_t   req_q;
  tag_res_t   res_q;
  tag_res_t   res_d;
  logic       wb_q;
  logic       wb_d;
  tag_entry_t wb_entry_q;
  tag_entry_t wb_entry_d;
  logic       accept;
  logic       res_done;
  logic       is_lookup;
  logic       build_res;
  way_ind_t   sel_way;
  tag_entry_t sel_entry;
  tag_entry_t hit_entry;

  assign ready_o      = state_q == IDLE;
  assign valid_o      = state_q == RESPOND;
  assign res_o        = res_q;
  assign accept       = ready_o && valid_i;
  assign res_done     = valid_o && ready_i;
  assign is_lookup    = req_q.op == OP_LOOKUP;
  assign build_res    = (state_q == READ) && data_phase_q;
  assign lookup_tag_o = req_q.tag;
  assign hit_entry    = entries_i[hit_bin_i];

  // Way whose stored line decides evict and evict_tag
  always_comb begin
    if (!is_lookup) begin
      sel_way = req_q.flush_way;
    end else if (found_i) begin
      sel_way = victim_i;
    end else begin
      sel_way = '0;
    end
  end

  // One-hot mux, only ways that returned read data count
  always_comb begin
    sel_entry = '0;
    for (int unsigned w = 0; w < NUM_WAYS; w++) begin
      if (sel_way[w] && rvalid_i[w]) begin
        sel_entry = sel_entry | entries_i[w];
      end
    end
  end

  // Result and pending write-back for the current operation
  always_comb begin
    res_d      = '0;
    wb_d       = 1'b0;
    wb_entry_d = '0;
    advance_o  = 1'b0;
    if (is_lookup && (|hit_i)) begin
      res_d.way  = hit_i;
      res_d.hit  = 1'b1;
      // Dirty request on a clean line marks it dirty
      wb_d       = req_q.dirty && !hit_entry.dirty;
      wb_entry_d = '{valid: 1'b1, dirty: 1'b1, tag: req_q.tag};
    end else if (is_lookup) begin
      res_d.way       = sel_way;
      res_d.evict     = sel_entry.valid && sel_entry.dirty;
      res_d.evict_tag = sel_entry.tag;
      wb_d            = found_i;
      wb_entry_d      = '{valid: 1'b1, dirty: req_q.dirty, tag: req_q.tag};
      // A valid victim means round-robin made the choice
      advance_o       = build_res && found_i && sel_entry.valid;
    end else begin
      res_d.way       = sel_way;
      res_d.evict     = sel_entry.valid && sel_entry.dirty;
      res_d.evict_tag = sel_entry.tag;
      // Flush leaves the entry all zero
      wb_d            = 1'b1;
    end
  end

  // FSM
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= IDLE;
      data_phase_q <= 1'b0;
      wb_q         <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q      <= READ;
            data_phase_q <= 1'b0;
          end
        end
        READ: begin
          data_phase_q <= !data_phase_q;
          if (data_phase_q) begin
            state_q <= RESPOND;
            wb_q    <= wb_d;
          end
        end
        RESPOND: begin
          if (res_done) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request and result payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
    if (build_res) begin
      res_q      <= res_d;
      wb_entry_q <= wb_entry_d;
    end
  end

  // Read in the first READ cycle, write-back on the result handshake
  always_comb begin
    ram_req_o   = '0;
    ram_we_o    = '0;
    ram_wdata_o = wb_entry_q;
    if ((state_q == READ) && !data_phase_q) begin
      ram_req_o = is_lookup ? {NUM_WAYS{1'b1}} : req_q.flush_way;
    end else if (res_done && wb_q) begin
      ram_req_o = res_q.way;
      ram_we_o  = res_q.way;
    end
  end

  assign ram_index_o = req_q.index;

endmodule

//--- tag_store.sv
// Tag store top level
// Per-way tag SRAMs, hit detection, victim selection and controller
`timescale 1ns/1ps
module tag_store (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  tag_store_pkg::tag_req_t req_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  output tag_store_pkg::tag_res_t res_o,
  output logic                    valid_o,
  input  logic                    ready_i,
  input  tag_store_pkg::way_ind_t spm_lock_i
);
  import tag_store_pkg::*;

  way_ind_t     ram_req;
  way_ind_t     ram_we;
  way_ind_t     ram_rvalid;
  index_t       ram_index;
  tag_entry_t   ram_wdata;
  tag_entries_t entries;
  way_ind_t     hit;
  way_bin_t     hit_bin;
  way_ind_t     victim;
  logic         found;
  logic         advance;
  tag_t         lookup_tag;

  // One memory per way, shared index and write word
  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_ways
    tag_sram u_sram (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .req_i    (ram_req[w]),
      .we_i     (ram_we[w]),
      .index_i  (ram_index),
      .wdata_i  (ram_wdata),
      .rdata_o  (entries[w]),
      .rvalid_o (ram_rvalid[w])
    );
  end

  tag_hit_detect u_hit (
    .entries_i (entries),
    .tag_i     (lookup_tag),
    .lock_i    (spm_lock_i),
    .hit_o     (hit),
    .hit_bin_o (hit_bin)
  );

  victim_select u_victim (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .entries_i (entries),
    .lock_i    (spm_lock_i),
    .advance_i (advance),
    .victim_o  (victim),
    .found_o   (found)
  );

  tag_store_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (req_i),
    .valid_i      (valid_i),
    .ready_o      (ready_o),
    .res_o        (res_o),
    .valid_o      (valid_o),
    .ready_i      (ready_i),
    .ram_req_o    (ram_req),
    .ram_we_o     (ram_we),
    .ram_index_o  (ram_index),
    .ram_wdata_o  (ram_wdata),
    .entries_i    (entries),
    .rvalid_i     (ram_rvalid),
    .hit_i        (hit),
    .hit_bin_i    (hit_bin),
    .victim_i     (victim),
    .found_i      (found),
    .advance_o    (advance),
    .lookup_tag_o (lookup_tag)
  );

endmodule

//--- tag_store_properties.sv
// Concurrent checks on the tag store controller
// One-hot hit, result hold under back-pressure, handshake exclusion, write timing
`timescale 1ns/1ps
module tag_store_properties (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input logic                    req_ready_i,
  input logic                    res_valid_i,
  input logic                    res_ready_i,
  input tag_store_pkg::tag_res_t res_i,
  input tag_store_pkg::way_ind_t hit_i,
  input logic                    build_res_i,
  input logic                    is_lookup_i,
  input tag_store_pkg::way_ind_t ram_we_i
);

  // A set never holds the same tag twice in its unlocked ways
  hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    build_res_i && is_lookup_i |-> $onehot0(hit_i))
    else $error("Hit vector has more than one way set");

  // Result channel holds while the consumer stalls
  res_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_i))
    else $error("Result changed or dropped under back-pressure");

  // One request in flight at a time
  ready_valid_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(req_ready_i && res_valid_i))
    else $error("Request ready and result valid high together");

  // Write-back only on the result handshake
  write_on_handshake: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    |ram_we_i |-> res_valid_i && res_ready_i)
    else $error("SRAM write outside a result handshake");

endmodule

bind tag_store_ctrl tag_store_properties u_props (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .req_ready_i (ready_o),
  .res_valid_i (valid_o),
  .res_ready_i (ready_i),
  .res_i       (res_o),
  .hit_i       (hit_i),
  .build_res_i (build_res),
  .is_lookup_i (is_lookup),
  .ram_we_i    (ram_we_o)
);

//--- tb_tag_store.sv
// Testbench of the tag store
// Clock and reset, transaction table, LFSR back-pressure, compare tasks, watchdog
`timescale 1ns/1ps
module tb_tag_store;
  import tag_store_pkg::*;

  localparam int unsigned CLK_PERIOD      = 100;
  localparam int unsigned DRIVE_DLY       = 1;
  localparam int unsigned RESET_CYCLES    = 3;
  // Budget per table entry before the run counts as hung
  localparam int unsigned CYCLES_PER_STEP = 40;

  // One transaction with its expected result
  typedef struct {
    string    name;
    tag_req_t req;
    way_ind_t lock;
    tag_res_t exp;
    logic     bp;
  } step_t;

  logic        clk_i;
  logic        rst_n_i;
  tag_req_t    req_i;
  logic        valid_i;
  logic        ready_o;
  tag_res_t    res_o;
  logic        valid_o;
  logic        ready_i;
  way_ind_t    spm_lock_i;
  step_t       steps[$];
  logic        table_built;
  logic [15:0] lfsr_q;

  tag_store u_dut (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .valid_i    (valid_i),
    .ready_o    (ready_o),
    .res_o      (res_o),
    .valid_o    (valid_o),
    .ready_i    (ready_i),
    .spm_lock_i (spm_lock_i)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Fibonacci LFSR x^16+x^14+x^13+x^11+1, one step per bit taken
  function automatic int unsigned random_bits(input int unsigned n);
    int unsigned val;
    logic        fb;
    val = 0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic tag_req_t lookup_req(input index_t index, input tag_t tag,
                                          input logic dirty);
    tag_req_t r;
    r       = '0;
    r.op    = OP_LOOKUP;
    r.index = index;
    r.tag   = tag;
    r.dirty = dirty;
    return r;
  endfunction

  function automatic tag_req_t flush_req(input index_t index, input way_ind_t way);
    tag_req_t r;
    r           = '0;
    r.op        = OP_FLUSH;
    r.index     = index;
    r.flush_way = way;
    return r;
  endfunction

  function automatic tag_res_t exp_res(input way_ind_t way, input logic hit,
                                       input logic evict, input tag_t evict_tag);
    tag_res_t r;
    r.way       = way;
    r.hit       = hit;
    r.evict     = evict;
    r.evict_tag = evict_tag;
    return r;
  endfunction

  function automatic void add_step(input string name, input tag_req_t req,
                                   input way_ind_t lock, input tag_res_t exp, input logic bp);
    step_t s;
    s.name = name;
    s.req  = req;
    s.lock = lock;
    s.exp  = exp;
    s.bp   = bp;
    steps.push_back(s);
  endfunction

  // Expected results follow the victim rule with a global pointer starting at 0
  task automatic build_table;
    // Empty set fills from way 0, then the same tag hits
    add_step("miss_empty", lookup_req(4'd1, 8'h11, 1'b0), 4'h0, exp_res(4'h1, 0, 0, 8'h00), 0);
    add_step("hit_way0", lookup_req(4'd1, 8'h11, 1'b0), 4'h0, exp_res(4'h1, 1, 0, 8'h00), 0);
    // Dirty hit on a clean line, way 0 becomes dirty
    add_step("hit_mark_dirty", lookup_req(4'd1, 8'h11, 1'b1), 4'h0, exp_res(4'h1, 1, 0, 8'h00), 1);
    add_step("fill_s1_w1", lookup_req(4'd1, 8'h22, 1'b0), 4'h0, exp_res(4'h2, 0, 0, 8'h00), 0);
    add_step("fill_s1_w2", lookup_req(4'd1, 8'h33, 1'b0), 4'h0, exp_res(4'h4, 0, 0, 8'h00), 0);
    add_step("fill_s1_w3", lookup_req(4'd1, 8'h44, 1'b0), 4'h0, exp_res(4'h8, 0, 0, 8'h00), 0);
    // Full set, pointer at 0, dirty way 0 goes out; pointer moves to 1
    add_step("evict_dirty_w0", lookup_req(4'd1, 8'h55, 1'b0), 4'h0, exp_res(4'h1, 0, 1, 8'h11), 1);
    add_step("fill_s2_w0", lookup_req(4'd2, 8'h61, 1'b0), 4'h0, exp_res(4'h1, 0, 0, 8'h00), 0);
    add_step("fill_s2_w1", lookup_req(4'd2, 8'h62, 1'b0), 4'h0, exp_res(4'h2, 0, 0, 8'h00), 0);
    add_step("fill_s2_w2", lookup_req(4'd2, 8'h63, 1'b0), 4'h0, exp_res(4'h4, 0, 0, 8'h00), 0);
    add_step("fill_s2_w3", lookup_req(4'd2, 8'h64, 1'b0), 4'h0, exp_res(4'h8, 0, 0, 8'h00), 0);
    // Round-robin continues at way 1 in another set; pointer to 2
    add_step("rr_s2_w1", lookup_req(4'd2, 8'h65, 1'b0), 4'h0, exp_res(4'h2, 0, 0, 8'h62), 1);
    add_step("fill_s3_w0", lookup_req(4'd3, 8'h71, 1'b0), 4'h0, exp_res(4'h1, 0, 0, 8'h00), 0);
    // Way 0 locked as scratchpad, its tag no longer hits
    add_step("lock_no_hit", lookup_req(4'd3, 8'h71, 1'b0), 4'h1, exp_res(4'h2, 0, 0, 8'h00), 0);
    add_step("lock_fill_w2", lookup_req(4'd3, 8'h72, 1'b0), 4'h1, exp_res(4'h4, 0, 0, 8'h00), 0);
    add_step("lock_fill_w3", lookup_req(4'd3, 8'h73, 1'b0), 4'h1, exp_res(4'h8, 0, 0, 8'h00), 0);
    add_step("lock_rr_w2", lookup_req(4'd3, 8'h74, 1'b0), 4'h1, exp_res(4'h4, 0, 0, 8'h72), 0);
    add_step("lock_rr_w3", lookup_req(4'd3, 8'h75, 1'b0), 4'h1, exp_res(4'h8, 0, 0, 8'h73), 1);
    // Pointer wrapped to locked way 0, so way 1 is chosen
    add_step("lock_rr_skip", lookup_req(4'd3, 8'h76, 1'b0), 4'h1, exp_res(4'h2, 0, 0, 8'h71), 0);
    add_step("all_locked", lookup_req(4'd3, 8'h76, 1'b0), 4'hf, exp_res(4'h0, 0, 0, 8'h00), 0);
    add_step("hit_dirty_w2", lookup_req(4'd1, 8'h33, 1'b1), 4'h0, exp_res(4'h4, 1, 0, 8'h00), 0);
    add_step("flush_dirty", flush_req(4'd1, 4'h4), 4'h0, exp_res(4'h4, 0, 1, 8'h33), 1);
    add_step("flush_clean", flush_req(4'd1, 4'h2), 4'h0, exp_res(4'h2, 0, 0, 8'h22), 0);
    // Flushed tag misses, lowest cleared way takes it
    add_step("miss_after_flush", lookup_req(4'd1, 8'h33, 1'b0), 4'h0,
             exp_res(4'h2, 0, 0, 8'h00), 0);
    add_step("dirty_miss_w2", lookup_req(4'd2, 8'h66, 1'b1), 4'h0, exp_res(4'h4, 0, 0, 8'h63), 1);
    add_step("hit_dirty_line", lookup_req(4'd2, 8'h66, 1'b0), 4'h0, exp_res(4'h4, 1, 0, 8'h00), 0);
    add_step("flush_miss_line", flush_req(4'd2, 4'h4), 4'h0, exp_res(4'h4, 0, 1, 8'h66), 0);
  endtask

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Fields in order way/hit/evict/evict_tag
  task automatic compare_res(input string name, input tag_res_t exp, input tag_res_t act);
    if (act !== exp) begin
      fail_run($sformatf("** Error %s: expected %b/%b/%b/%h, actual %b/%b/%b/%h", name,
                         exp.way, exp.hit, exp.evict, exp.evict_tag,
                         act.way, act.hit, act.evict, act.evict_tag));
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  // Sample and drive just after the rising edge
  task automatic next_cycle;
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic apply_step(input step_t s);
    int unsigned hold_cycles;
    while (!ready_o) begin
      next_cycle();
    end
    req_i      = s.req;
    valid_i    = 1'b1;
    spm_lock_i = s.lock;
    ready_i    = !s.bp;
    // Accept edge
    next_cycle();
    valid_i = 1'b0;
    compare_bit({s.name, " ready_o after accept"}, 1'b0, ready_o);
    next_cycle();
    compare_bit({s.name, " valid_o 1 cycle after accept"}, 1'b0, valid_o);
    next_cycle();
    compare_bit({s.name, " valid_o 2 cycles after accept"}, 1'b1, valid_o);
    compare_res(s.name, s.exp, res_o);
    if (s.bp) begin
      hold_cycles = random_bits(3) + 1;
      repeat (hold_cycles) begin
        next_cycle();
        compare_bit({s.name, " valid_o held"}, 1'b1, valid_o);
        compare_res({s.name, " held"}, s.exp, res_o);
      end
      ready_i = 1'b1;
    end
    // Result handshake edge
    next_cycle();
    compare_bit({s.name, " valid_o after handshake"}, 1'b0, valid_o);
    compare_bit({s.name, " ready_o after handshake"}, 1'b1, ready_o);
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    req_i       = '0;
    valid_i     = 1'b0;
    ready_i     = 1'b1;
    spm_lock_i  = '0;
    lfsr_q      = 16'd6012;
    table_built = 1'b0;
    build_table();
    table_built = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    rst_n_i = 1'b1;
    compare_bit("ready_o after reset", 1'b1, ready_o);
    compare_bit("valid_o after reset", 1'b0, valid_o);
    foreach (steps[i]) begin
      apply_step(steps[i]);
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

  // Watchdog sized from the table length
  initial begin : watchdog
    wait (table_built);
    repeat (steps.size() * CYCLES_PER_STEP) @(posedge clk_i);
    fail_run($sformatf("Timeout: the tests did not finish within %0d cycles",
                       steps.size() * CYCLES_PER_STEP));
  end

endmodule

//--- build.f
tag_store_pkg.sv
tag_sram.sv
tag_hit_detect.sv
victim_select.sv
tag_store_ctrl.sv
tag_store.sv
tag_store_properties.sv
tb_tag_store.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the tag store testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_tag_store -f build.f -o sim_tag_store
./obj_dir/sim_tag_store
